//--- tb.f
source/memory_game_pkg.sv
source/hex7seg.sv
source/sequence_rom.sv
source/game_datapath.sv
source/game_control.sv
source/memory_game.sv
verif/memory_game_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := memory_game_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/memory_game_tb.sv
`timescale 1ns/1ns
`default_nettype none

module memory_game_tb import memory_game_pkg::*; ();

    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_WRONG,
        FAULT_SILENT
    } fault_t;

    typedef struct packed {
        logic   mode;
        count_t fault_at;
        fault_t fault;
        logic   expect_won;
        logic   expect_timed_out;
    } row_t;

    localparam int NUM_ROWS    = 9;
    localparam int CYCLE_LIMIT = NUM_ROWS * (16 * 10 + TIMEOUT_CYCLES + 20);
    localparam int END_WAIT    = TIMEOUT_CYCLES + 10;

    // Segments of the hex digits 0 to F with segment a in bit 0.
    localparam seg_t SEG_TABLE [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    logic        clock;
    logic        arst_n;
    logic        start;
    logic        mode;
    move_t       switches;
    logic        ready;
    logic        won_out;
    logic        lost_out;
    logic        timed_out;
    move_t       leds;
    seg_t        disp_count;
    seg_t        disp_rom;
    seg_t        disp_move;
    seg_t        disp_state;
    row_t        rows [NUM_ROWS];
    int          mismatches;
    int          failures;
    int          cycles;
    logic [16:0] lfsr_state;

    memory_game i_memory_game (
        .clock      (clock),
        .arst_n     (arst_n),
        .start      (start),
        .mode       (mode),
        .switches   (switches),
        .ready      (ready),
        .won_out    (won_out),
        .lost_out   (lost_out),
        .timed_out  (timed_out),
        .leds       (leds),
        .disp_count (disp_count),
        .disp_rom   (disp_rom),
        .disp_move  (disp_move),
        .disp_state (disp_state)
    );

    // The move at index i lights switch (i + i/4) mod 4.
    function automatic move_t expected_word(input count_t index);
        int pos;
        pos = (int'(index) + int'(index) / 4) % 4;
        return move_t'(4'b0001 << pos);
    endfunction

    // Fibonacci form with taps at bits 17 and 14.
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic pick_wrong(input move_t expected, output move_t word);
        int pos;
        word = expected;
        while (word == expected) begin
            draw_bits(2, pos);
            word = move_t'(4'b0001 << pos);
        end
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        assert (got == exp) else begin
            mismatches++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("%s at %0t", what, $time);
    endtask

    task automatic wait_round_end(input int limit);
        int n;
        n = 0;
        while (!ready && n < limit) begin
            @(negedge clock);
            n++;
        end
        assert (ready) else report_failure("round did not end within the wait limit");
    endtask

    // Three cycles of the move, then five with all switches off.
    task automatic apply_move(input move_t word);
        switches = word;
        repeat (3) @(negedge clock);
        switches = '0;
        repeat (5) @(negedge clock);
    endtask

    task automatic play_row(input row_t row);
        count_t last_index;
        move_t  exp_word;
        move_t  word;
        logic   done;
        last_index = row.mode ? FULL_LAST : SHORT_LAST;
        mode  = row.mode;
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        @(negedge clock);
        check_value("ready", 8'(ready), 8'h00);
        check_value("won_out", 8'(won_out), 8'h00);
        check_value("lost_out", 8'(lost_out), 8'h00);
        check_value("timed_out", 8'(timed_out), 8'h00);
        done = 1'b0;
        for (int i = 0; i <= int'(last_index) && !done; i++) begin
            exp_word = expected_word(count_t'(i));
            check_value("leds", 8'(leds), 8'(exp_word));
            check_value("disp_rom", 8'(disp_rom), 8'(SEG_TABLE[exp_word]));
            check_value("disp_count", 8'(disp_count), 8'(SEG_TABLE[i]));
            if (row.fault == FAULT_SILENT && int'(row.fault_at) == i) begin
                wait_round_end(END_WAIT); // Nothing is driven, so the timer ends the round.
                done = 1'b1;
            end else begin
                word = exp_word;
                if (row.fault == FAULT_WRONG && int'(row.fault_at) == i) begin
                    pick_wrong(exp_word, word);
                    done = 1'b1;
                end
                apply_move(word);
                if (i == int'(last_index)) begin
                    done = 1'b1;
                end
                if (done) begin
                    wait_round_end(END_WAIT);
                    check_value("disp_move", 8'(disp_move), 8'(SEG_TABLE[word]));
                end else begin
                    check_value("ready", 8'(ready), 8'h00);
                end
            end
        end
        check_value("ready", 8'(ready), 8'h01);
        check_value("won_out", 8'(won_out), 8'(row.expect_won));
        check_value("lost_out", 8'(lost_out), 8'(!row.expect_won));
        check_value("timed_out", 8'(timed_out), 8'(row.expect_timed_out));
        check_value("disp_state", 8'(disp_state),
                    8'(SEG_TABLE[row.expect_won ? 6 : 7]));
    endtask

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing", cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        arst_n     = 1'b0;
        start      = 1'b0;
        mode       = 1'b0;
        switches   = '0;
        mismatches = 0;
        failures   = 0;
        lfsr_state = 17'd81996;

        // Mode, fault index, fault kind, won, timed out.
        rows[0] = '{1'b0, 4'd0,  FAULT_NONE,   1'b1, 1'b0};
        rows[1] = '{1'b1, 4'd0,  FAULT_NONE,   1'b1, 1'b0};
        rows[2] = '{1'b0, 4'd2,  FAULT_WRONG,  1'b0, 1'b0};
        rows[3] = '{1'b1, 4'd9,  FAULT_WRONG,  1'b0, 1'b0};
        rows[4] = '{1'b0, 4'd1,  FAULT_SILENT, 1'b0, 1'b1};
        rows[5] = '{1'b1, 4'd15, FAULT_WRONG,  1'b0, 1'b0};
        rows[6] = '{1'b0, 4'd0,  FAULT_WRONG,  1'b0, 1'b0};
        rows[7] = '{1'b1, 4'd12, FAULT_SILENT, 1'b0, 1'b1};
        rows[8] = '{1'b0, 4'd0,  FAULT_NONE,   1'b1, 1'b0};

        repeat (4) @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);
        check_value("ready", 8'(ready), 8'h01);
        check_value("won_out", 8'(won_out), 8'h00);
        check_value("lost_out", 8'(lost_out), 8'h00);
        check_value("timed_out", 8'(timed_out), 8'h00);

        for (int r = 0; r < NUM_ROWS; r++) begin
            play_row(rows[r]);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/memory_game.sv
`timescale 1ns/1ns
`default_nettype none

module memory_game import memory_game_pkg::*; (
    input  wire logic clock,
    input  wire logic arst_n,
    input  wire logic start,
    input  wire logic mode,
    input  move_t     switches,
    output logic      ready,
    output logic      won_out,
    output logic      lost_out,
    output logic      timed_out,
    output move_t     leds,
    output seg_t      disp_count,
    output seg_t      disp_rom,
    output seg_t      disp_move,
    output seg_t      disp_state
);

    logic   clear;
    logic   store;
    logic   step;
    logic   timer_en;
    logic   move_seen;
    logic   match;
    logic   last;
    logic   timeout;
    count_t count;
    move_t  move;
    state_t state;

    game_datapath i_game_datapath (
        .clock     (clock),
        .arst_n    (arst_n),
        .switches  (switches),
        .mode      (mode),
        .clear     (clear),
        .store     (store),
        .step      (step),
        .timer_en  (timer_en),
        .move_seen (move_seen),
        .match     (match),
        .last      (last),
        .timeout   (timeout),
        .count     (count),
        .rom_word  (leds),     // The player sees the expected move.
        .move      (move)
    );

    game_control i_game_control (
        .clock     (clock),
        .arst_n    (arst_n),
        .start     (start),
        .move_seen (move_seen),
        .match     (match),
        .last      (last),
        .timeout   (timeout),
        .clear     (clear),
        .store     (store),
        .step      (step),
        .timer_en  (timer_en),
        .ready     (ready),
        .won_out   (won_out),
        .lost_out  (lost_out),
        .timed_out (timed_out),
        .state     (state)
    );

    hex7seg i_hex_count (.value(count), .seg(disp_count));
    hex7seg i_hex_rom   (.value(leds),  .seg(disp_rom));
    hex7seg i_hex_move  (.value(move),  .seg(disp_move));
    hex7seg i_hex_state (.value(state), .seg(disp_state));

endmodule

`default_nettype wire

//--- source/game_control.sv
`timescale 1ns/1ns
`default_nettype none

module game_control import memory_game_pkg::*; (
    input  wire logic clock,
    input  wire logic arst_n,
    input  wire logic start,
    input  wire logic move_seen,
    input  wire logic match,
    input  wire logic last,
    input  wire logic timeout,
    output logic      clear,
    output logic      store,
    output logic      step,
    output logic      timer_en,
    output logic      ready,
    output logic      won_out,
    output logic      lost_out,
    output logic      timed_out,
    output state_t    state
);

    state_t next_state;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE, S_WON, S_LOST: begin
                if (start) begin
                    next_state = S_PREPARE;
                end
            end
            S_PREPARE: next_state = S_WAIT_MOVE;
            S_WAIT_MOVE: begin
                // A move in the same cycle as the timeout still counts.
                if (move_seen) begin
                    next_state = S_STORE_MOVE;
                end else if (timeout) begin
                    next_state = S_LOST;
                end
            end
            S_STORE_MOVE: next_state = S_COMPARE;
            S_COMPARE: begin
                if (!match) begin
                    next_state = S_LOST;
                end else if (last) begin
                    next_state = S_WON;
                end else begin
                    next_state = S_ADVANCE;
                end
            end
            S_ADVANCE: next_state = S_WAIT_MOVE;
            default:   next_state = S_IDLE;
        endcase
    end

    // Remembers that the loss came from silence rather than a wrong move.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            timed_out <= 1'b0;
        end else if (state == S_PREPARE) begin
            timed_out <= 1'b0;
        end else if (state == S_WAIT_MOVE && timeout && !move_seen) begin
            timed_out <= 1'b1;
        end
    end

    assign clear    = (state == S_PREPARE);
    assign store    = (state == S_STORE_MOVE);
    assign step     = (state == S_ADVANCE);
    assign timer_en = (state == S_WAIT_MOVE);
    assign won_out  = (state == S_WON);
    assign lost_out = (state == S_LOST);
    assign ready    = (state == S_IDLE) || won_out || lost_out;

endmodule

`default_nettype wire

//--- source/game_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module game_datapath import memory_game_pkg::*; (
    input  wire logic clock,
    input  wire logic arst_n,
    input  move_t     switches,
    input  wire logic mode,
    input  wire logic clear,
    input  wire logic store,
    input  wire logic step,
    input  wire logic timer_en,
    output logic      move_seen,
    output logic      match,
    output logic      last,
    output logic      timeout,
    output count_t    count,
    output move_t     rom_word,
    output move_t     move
);

    logic   any_on;
    logic   any_on_q;
    logic   mode_q;
    timer_t timer_q;

    sequence_rom i_sequence_rom (
        .addr (count),
        .word (rom_word)
    );

    // A move starts when the switches leave the all-zero state.
    assign any_on    = |switches;
    assign move_seen = any_on & ~any_on_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            any_on_q <= 1'b0;
        end else begin
            any_on_q <= any_on;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count  <= '0;
            move   <= '0;
            mode_q <= 1'b0;
        end else if (clear) begin
            count  <= '0;
            move   <= '0;
            mode_q <= mode; // Mode is fixed for the whole round.
        end else begin
            if (store) begin
                move <= switches;
            end
            if (step) begin
                count <= count + 4'd1;
            end
        end
    end

    // Idle cycle counter, restarted for every move.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            timer_q <= '0;
        end else if (clear || step) begin
            timer_q <= '0;
        end else if (timer_en && !timeout) begin
            timer_q <= timer_q + timer_t'(1);
        end
    end

    assign timeout = (timer_q == timer_t'(TIMEOUT_CYCLES));
    assign match   = (move == rom_word);
    assign last    = (count == (mode_q ? FULL_LAST : SHORT_LAST));

endmodule

`default_nettype wire

//--- source/sequence_rom.sv
`timescale 1ns/1ns
`default_nettype none

module sequence_rom import memory_game_pkg::*; (
    input  count_t addr,
    output move_t  word
);

    // Each group of four entries walks the switches, rotated by one more
    // position than the group before it.
    always_comb begin
        case (addr)
            4'd0:    word = 4'b0001;
            4'd1:    word = 4'b0010;
            4'd2:    word = 4'b0100;
            4'd3:    word = 4'b1000;
            4'd4:    word = 4'b0010;
            4'd5:    word = 4'b0100;
            4'd6:    word = 4'b1000;
            4'd7:    word = 4'b0001;
            4'd8:    word = 4'b0100;
            4'd9:    word = 4'b1000;
            4'd10:   word = 4'b0001;
            4'd11:   word = 4'b0010;
            4'd12:   word = 4'b1000;
            4'd13:   word = 4'b0001;
            4'd14:   word = 4'b0010;
            default: word = 4'b0100;
        endcase
    end

endmodule

`default_nettype wire

//--- source/hex7seg.sv
`timescale 1ns/1ns
`default_nettype none

module hex7seg import memory_game_pkg::*; (
    input  wire logic [3:0] value,
    output seg_t            seg
);

    // Segments are active high with g in bit 6 down to a in bit 0.
    always_comb begin
        case (value)
            4'h0:    seg = 7'b0111111;
            4'h1:    seg = 7'b0000110;
            4'h2:    seg = 7'b1011011;
            4'h3:    seg = 7'b1001111;
            4'h4:    seg = 7'b1100110;
            4'h5:    seg = 7'b1101101;
            4'h6:    seg = 7'b1111101;
            4'h7:    seg = 7'b0000111;
            4'h8:    seg = 7'b1111111;
            4'h9:    seg = 7'b1101111;
            4'ha:    seg = 7'b1110111;
            4'hb:    seg = 7'b1111100; // Lower case b.
            4'hc:    seg = 7'b0111001;
            4'hd:    seg = 7'b1011110; // Lower case d.
            4'he:    seg = 7'b1111001;
            default: seg = 7'b1110001;
        endcase
    end

endmodule

`default_nettype wire

//--- source/memory_game_pkg.sv
`default_nettype none

package memory_game_pkg;

    typedef logic [3:0] move_t;   // One-hot when it holds a valid move.
    typedef logic [3:0] count_t;  // Move index within a round.
    typedef logic [6:0] seg_t;    // Bit 0 is segment a, bit 6 is segment g.

    localparam count_t SHORT_LAST = 4'd3;
    localparam count_t FULL_LAST  = 4'd15;

    // Idle cycles allowed in wait_move before the round is lost.
    localparam int TIMEOUT_CYCLES = 50;
    localparam int TIMER_W        = $clog2(TIMEOUT_CYCLES + 1);

    typedef logic [TIMER_W-1:0] timer_t;

    // The display shows these codes, so the encodings are fixed.
    typedef enum logic [3:0] {
        S_IDLE       = 4'd0,
        S_PREPARE    = 4'd1,
        S_WAIT_MOVE  = 4'd2,
        S_STORE_MOVE = 4'd3,
        S_COMPARE    = 4'd4,
        S_ADVANCE    = 4'd5,
        S_WON        = 4'd6,
        S_LOST       = 4'd7
    } state_t;

endpackage

`default_nettype wire
